/* build.f */
+incdir+verilog
verilog/mskPkg.sv
verilog/inFifo.sv
verilog/mskModulator.sv
verilog/testMux.sv
verilog/mskTop.sv
test/mskTop_chk.sv
test/mskTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator from the project root, then run the testbench
verilator --binary --assert --timing -f build.f --top-module mskTb -o mskSim \
	&& ./obj_dir/mskSim \
	|| { echo "Simulation did not complete cleanly"; exit 1; }

/* test/mskTb.sv */
`timescale 1ns/100ps

module mskTb
	import mskPkg::*;
();

	localparam int DriveDelay = 10;
	localparam int NameW = 8 * 24;
	localparam int LineW = 8 * 96;

	logic   inClock;
	logic   rstN;
	logic   writeEnable;
	nibbleT writeData;
	logic   bypassEn;
	logic   bypassBit;
	obsSelT obsSel;
	sampleT sinI;
	sampleT sinQ;
	logic   sampleValid;
	logic   full;
	sampleT obsData;
	logic   obsFlag;

	// Captured I/Q pairs oldest first
	logic [7:0] gotPairs [$];
	logic [LineW-1:0] traceLines [$];

	int cycleCount = 0;
	int cycleLimit = 0;

	mskTop u_mskTop (
		.inClock     (inClock),
		.rstN        (rstN),
		.writeEnable (writeEnable),
		.writeData   (writeData),
		.bypassEn    (bypassEn),
		.bypassBit   (bypassBit),
		.obsSel      (obsSel),
		.sinI        (sinI),
		.sinQ        (sinQ),
		.sampleValid (sampleValid),
		.full        (full),
		.obsData     (obsData),
		.obsFlag     (obsFlag)
	);

	//////////////////////////////
	// Clock, monitor, watchdog
	//////////////////////////////

	initial begin
		inClock = 1'b0;
		forever #50 inClock = ~inClock;
	end

	// Outputs settle long before the falling edge
	always @(negedge inClock) begin
		if (rstN && sampleValid) begin
			gotPairs.push_back({sinI, sinQ});
		end
	end

	always @(posedge inClock) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount > cycleLimit) begin
			stopRun($sformatf("Timeout, no progress after %0d cycles", cycleLimit));
		end
	end

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "Simulation stopped");
	endtask

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic checkSample(input logic [NameW-1:0] testName, input sampleT expVal,
		input sampleT gotVal);
		if (gotVal !== expVal) begin
			$display("ERR %0s expected %0h actual %0h", testName, expVal, gotVal);
			stopRun("Sample value mismatch");
		end
	endtask

	task automatic checkLevel(input logic [NameW-1:0] testName, input levelT expVal,
		input levelT gotVal);
		if (gotVal !== expVal) begin
			$display("ERR %0s expected %0d actual %0d", testName, expVal, gotVal);
			stopRun("FIFO level mismatch");
		end
	endtask

	task automatic checkBit(input logic [NameW-1:0] testName, input logic expVal,
		input logic gotVal);
		if (gotVal !== expVal) begin
			$display("ERR %0s expected %0b actual %0b", testName, expVal, gotVal);
			stopRun("Flag mismatch");
		end
	endtask

	//////////////////////////////
	// Trace commands
	//////////////////////////////

	task automatic writeNibble(input nibbleT value);
		@(posedge inClock);
		#DriveDelay;
		writeEnable = 1'b1;
		writeData = value;
		@(posedge inClock);
		#DriveDelay;
		writeEnable = 1'b0;
	endtask

	task automatic setBypass(input logic enable, input logic pinBit);
		@(posedge inClock);
		#DriveDelay;
		bypassEn = enable;
		bypassBit = pinBit;
	endtask

	task automatic setObs(input obsSelT sel);
		@(posedge inClock);
		#DriveDelay;
		obsSel = sel;
	endtask

	// Select 2 carries the fill count and the full pin must agree with its flag
	task automatic expectObs(input logic [NameW-1:0] testName, input int expData,
		input logic expFlag);
		@(negedge inClock);
		if (obsSel == 2'd2) begin
			checkLevel(testName, levelT'(expData), levelT'(obsData));
			checkBit(testName, expFlag, full);
		end else begin
			checkSample(testName, sampleT'(expData), obsData);
		end
		checkBit(testName, expFlag, obsFlag);
	endtask

	// Pairs packed as hex digits with I before Q and the first pair leftmost
	task automatic expectSamples(input logic [NameW-1:0] testName, input int count,
		input logic [255:0] pairs);
		logic [7:0] pair;
		logic [7:0] got;
		for (int k = 0; k < count; k++) begin
			while (gotPairs.size() == 0) begin
				@(negedge inClock);
			end
			got = gotPairs.pop_front();
			pair = pairs[(count - 1 - k) * 8 +: 8];
			checkSample(testName, pair[7:4], got[7:4]);
			checkSample(testName, pair[3:0], got[3:0]);
		end
	endtask

	// Quiet for some cycles and nothing left over
	task automatic waitIdle(input logic [NameW-1:0] testName, input int quiet);
		int low;
		low = 0;
		while (low < quiet) begin
			@(negedge inClock);
			if (!sampleValid) begin
				low++;
			end else begin
				low = 0;
			end
		end
		if (gotPairs.size() != 0) begin
			stopRun($sformatf("Test %0s produced %0d more samples than expected",
				testName, gotPairs.size()));
		end
	endtask

	task automatic loadTrace();
		int fd;
		logic [LineW-1:0] lineBuf;
		fd = $fopen("test/msk_trace.txt", "r");
		if (fd == 0) begin
			stopRun("Cannot open the trace file test/msk_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				lineBuf = '0;
				if ($fgets(lineBuf, fd) > 0) begin
					traceLines.push_back(lineBuf);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runLine(input logic [LineW-1:0] lineBuf);
		logic [NameW-1:0] testName;
		logic [7:0] cmd;
		int argNum;
		logic [255:0] argHex;
		int code;
		code = $sscanf(lineBuf, "%s %s %d %h", testName, cmd, argNum, argHex);
		// Comment or blank line
		if (code < 4 || testName == NameW'("#")) begin
			return;
		end
		case (cmd)
			"W": writeNibble(nibbleT'(argNum));
			"B": setBypass(argNum != 0, argHex[0]);
			"O": setObs(obsSelT'(argNum));
			"E": expectObs(testName, argNum, argHex[0]);
			"S": expectSamples(testName, argNum, argHex);
			"I": waitIdle(testName, argNum);
			default: stopRun($sformatf("Unknown trace command in test %0s", testName));
		endcase
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		rstN = 1'b0;
		writeEnable = 1'b0;
		writeData = '0;
		bypassEn = 1'b0;
		bypassBit = 1'b0;
		obsSel = '0;
		loadTrace();
		// One nibble of samples with slack per trace line plus reset
		cycleLimit = traceLines.size() * 64 + 64;
		repeat (16) @(posedge inClock);
		#DriveDelay;
		rstN = 1'b1;
		foreach (traceLines[i]) begin
			runLine(traceLines[i]);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

/* test/mskTop_chk.sv */
`timescale 1ns/100ps
`include "msk_settings.svh"

module mskChk
	import mskPkg::*;
(
	input logic  inClock,
	input logic  rstN,
	input logic  fifoRead,
	input logic  empty,
	input levelT level,
	input logic  sampleValid
);

	// Length of the current sampleValid run
	int runCnt;

	always_ff @(posedge inClock) begin
		if (!rstN) begin
			runCnt <= 0;
		end else if (sampleValid) begin
			runCnt <= runCnt + 1;
		end else begin
			runCnt <= 0;
		end
	end

	//////////////////////////////
	// Protocol rules
	//////////////////////////////

	// No fetch from a dry FIFO through the bypass mux
	readWhileEmpty: assert property (@(posedge inClock) disable iff (!rstN)
		!(fifoRead && empty))
		else $error("FIFO read while the FIFO is empty");

	// Fill count stays inside the buffer
	fillBound: assert property (@(posedge inClock) disable iff (!rstN)
		level <= levelT'(`IN_FIFO_DEPTH))
		else $error("FIFO level outside 0 to depth");

	// Runs end only on a bit boundary
	wholeBits: assert property (@(posedge inClock) disable iff (!rstN)
		(!sampleValid && $past(sampleValid)) |-> (runCnt % `SAMPLES_PER_BIT == 0))
		else $error("sampleValid run is not a whole number of bits");

endmodule

bind mskTop mskChk u_mskChk (
	.inClock     (inClock),
	.rstN        (rstN),
	.fifoRead    (fifoRead),
	.empty       (empty),
	.level       (level),
	.sampleValid (sampleValid)
);

/* test/msk_trace.txt */
# test cmd num hex
# W nibble, B en bit, O sel, E data flag, S count pairs(I Q hex), I quiet cycles
single W 5 0
single S 16 8faeddeaf8eaddae8faeddeaf8eaddae
single I 4 0
backToBack W 3 0
backToBack W 12 0
backToBack S 16 8faeddeaf8e5d2a180a1d2e5f8eaddae
backToBack S 16 8f5e2d1a0815225180512215081a2d5e
backToBack I 4 0
underflow W 1 0
underflow S 16 8faeddeaf8eaddae8f5e2d1a08152251
underflow I 4 0
obsIdle O 0 0
obsIdle E 8 0
obsIdle O 1 0
obsIdle E 0 1
obsIdle O 2 0
obsIdle E 0 0
underflow W 2 0
underflow S 16 80a1d2e5f8e5d2a180a1d2e5f8eaddae
underflow I 4 0
bypass B 1 1
bypass W 15 0
bypass W 0 0
bypass W 5 0
bypass W 10 0
bypass W 15 0
bypass W 0 0
bypass W 5 0
bypass W 10 0
bypass W 3 0
bypass O 2 0
bypass E 8 1
bypass B 0 0
bypass S 20 8faeddeaf8e5d2a180512215081a2d5e8faeddea
drain S 16 f8e5d2a180512215081a2d5e8faeddea
drain S 16 f8eaddae8f5e2d1a0815225180a1d2e5
drain S 16 f8e5d2a180a1d2e5f8e5d2a180a1d2e5
drain S 16 f8eaddae8faeddeaf8eaddae8faeddea
drain S 16 f8e5d2a180512215081a2d5e8faeddea
drain S 16 f8eaddae8f5e2d1a0815225180a1d2e5
drain S 16 f8e5d2a180a1d2e5f8e5d2a180a1d2e5
drain S 16 f8eaddae8faeddeaf8eaddae8faeddea
drain I 4 0
obsEnd O 3 0
obsEnd E 4 1
obsEnd O 2 0
obsEnd E 0 0
obsEnd O 0 0
obsEnd E 15 0
obsEnd O 1 0
obsEnd E 8 1

/* verilog/inFifo.sv */
`timescale 1ns/100ps
`include "msk_settings.svh"

module inFifo
	import mskPkg::*;
(
	input  logic   inClock,
	input  logic   rstN,
	input  logic   writeEnable,
	input  nibbleT writeData,
	input  logic   readBit,
	output logic   dataBit,
	output logic   empty,
	output logic   full,
	output levelT  level
);

	//////////////////////////////
	// Sizes
	//////////////////////////////

	localparam int Depth = `IN_FIFO_DEPTH;
	localparam int PtrW = $clog2(Depth);
	// Bit pointer walks one nibble
	localparam int BitW = $clog2($bits(nibbleT));
	localparam logic [BitW-1:0] LastBit = BitW'($bits(nibbleT) - 1);

	//////////////////////////////
	// Storage and pointers
	//////////////////////////////

	nibbleT mem [Depth];

	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	// Next bit of the head nibble
	logic [BitW-1:0] bitPtr;

	logic pushEn;
	logic bitEn;
	logic popEn;

	// Circular increment, depth need not be a power of two
	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
		if (ptr == PtrW'(Depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Writes while full are lost
	assign pushEn = writeEnable && !full;

	// Bit consumed this edge
	assign bitEn = readBit && !empty;

	// Head nibble leaves after its last bit
	assign popEn = bitEn && (bitPtr == LastBit);

	// Status flags straight from the count
	assign empty = (level == '0);
	assign full = (level == levelT'(Depth));

	// Head nibble, LSB first
	assign dataBit = mem[rdPtr][bitPtr];

	// Data array
	always_ff @(posedge inClock) begin
		if (pushEn) begin
			mem[wrPtr] <= writeData;
		end
	end

	// Pointers and fill count
	always_ff @(posedge inClock) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			bitPtr <= '0;
			level <= '0;
		end else begin
			if (pushEn) begin
				wrPtr <= nextPtr(wrPtr);
			end
			// Wraps back to bit 0 on pop
			if (bitEn) begin
				bitPtr <= bitPtr + 1'b1;
			end
			if (popEn) begin
				rdPtr <= nextPtr(rdPtr);
			end
			// Push and pop together leave the count as is
			case ({pushEn, popEn})
				2'b10: begin
					level <= level + 1'b1;
				end
				2'b01: begin
					level <= level - 1'b1;
				end
				default: begin
					level <= level;
				end
			endcase
		end
	end

endmodule

/* verilog/mskModulator.sv */
`timescale 1ns/100ps
`include "msk_settings.svh"

module mskModulator
	import mskPkg::*;
(
	input  logic   inClock,
	input  logic   rstN,
	input  logic   modBit,
	input  logic   modEmpty,
	output logic   readBit,
	output sampleT sinI,
	output sampleT sinQ,
	output logic   sampleValid,
	output phaseT  phase
);

	//////////////////////////////
	// Constants
	//////////////////////////////

	localparam int CntW = $clog2(`SAMPLES_PER_BIT);
	localparam logic [CntW-1:0] LastSample = CntW'(`SAMPLES_PER_BIT - 1);

	// Quarter carrier cycle, Q leads I by this much
	localparam phaseT QuarterStep = phaseT'(2 ** (`PHASE_BITS - 2));

	// round(7.5 + 7.5*sin(2*pi*k/16))
	localparam sampleT SineTable [2 ** `PHASE_BITS] = '{
		4'd8,  4'd10, 4'd13, 4'd14,
		4'd15, 4'd14, 4'd13, 4'd10,
		4'd8,  4'd5,  4'd2,  4'd1,
		4'd0,  4'd1,  4'd2,  4'd5
	};

	//////////////////////////////
	// State
	//////////////////////////////

	modStateT state;

	// Sample slot inside the current bit
	logic [CntW-1:0] sampleCnt;

	// Bit being sent, picks step direction
	logic curBit;

	logic lastSample;
	phaseT phaseQ;

	// Final slot of a bit
	assign lastSample = (state == modRun) && (sampleCnt == LastSample);

	// Fetch from idle, or back to back at the end of a bit
	assign readBit = !modEmpty && ((state == modIdle) || lastSample);

	// Every run cycle carries one sample
	assign sampleValid = (state == modRun);

	//////////////////////////////
	// Sine lookup
	//////////////////////////////

	// Wraps mod 16
	assign phaseQ = phaseT'(phase + QuarterStep);

	assign sinI = SineTable[phase];
	assign sinQ = SineTable[phaseQ];

	// Bit latch, loaded with each fetch
	always_ff @(posedge inClock) begin
		if (readBit) begin
			curBit <= modBit;
		end
	end

	// FSM, slot counter and phase accumulator
	always_ff @(posedge inClock) begin
		if (!rstN) begin
			state <= modIdle;
			sampleCnt <= '0;
			phase <= '0;
		end else begin
			// One step per sample, quarter cycle per bit
			if (state == modRun) begin
				if (curBit) begin
					phase <= phase + 1'b1;
				end else begin
					phase <= phase - 1'b1;
				end
				sampleCnt <= sampleCnt + 1'b1;
			end

			if (readBit) begin
				// New bit starts at slot 0
				state <= modRun;
				sampleCnt <= '0;
			end else if (lastSample) begin
				// Underflow, phase stays where it ended
				state <= modIdle;
				sampleCnt <= '0;
			end
		end
	end

endmodule

/* verilog/mskPkg.sv */
`include "msk_settings.svh"

package mskPkg;

	// Host write word, sent LSB first
	typedef logic [3:0] nibbleT;

	// Offset-binary sine sample, mid scale near 8
	typedef logic [3:0] sampleT;

	// Phase accumulator index
	typedef logic [`PHASE_BITS-1:0] phaseT;

	// FIFO fill count, 0 up to full depth
	typedef logic [3:0] levelT;

	// Observation group select
	typedef logic [1:0] obsSelT;

	// Modulator FSM
	typedef enum logic {
		modIdle,
		modRun
	} modStateT;

endpackage

/* verilog/mskTop.sv */
`timescale 1ns/100ps

module mskTop
	import mskPkg::*;
(
	input  logic   inClock,
	input  logic   rstN,
	input  logic   writeEnable,
	input  nibbleT writeData,
	input  logic   bypassEn,
	input  logic   bypassBit,
	input  obsSelT obsSel,
	output sampleT sinI,
	output sampleT sinQ,
	output logic   sampleValid,
	output logic   full,
	output sampleT obsData,
	output logic   obsFlag
);

	//////////////////////////////
	// Internal wires
	//////////////////////////////

	// FIFO side
	logic  dataBit;
	logic  empty;
	levelT level;
	logic  fifoRead;

	// Modulator side
	logic  modBit;
	logic  modEmpty;
	logic  readBit;
	phaseT phase;

	// Bit source
	inFifo u_inFifo (
		.inClock     (inClock),
		.rstN        (rstN),
		.writeEnable (writeEnable),
		.writeData   (writeData),
		.readBit     (fifoRead),
		.dataBit     (dataBit),
		.empty       (empty),
		.full        (full),
		.level       (level)
	);

	// Bypass and observation
	testMux u_testMux (
		.bypassEn  (bypassEn),
		.bypassBit (bypassBit),
		.obsSel    (obsSel),
		.dataBit   (dataBit),
		.empty     (empty),
		.full      (full),
		.level     (level),
		.readBit   (readBit),
		.sinI      (sinI),
		.sinQ      (sinQ),
		.phase     (phase),
		.modBit    (modBit),
		.modEmpty  (modEmpty),
		.fifoRead  (fifoRead),
		.obsData   (obsData),
		.obsFlag   (obsFlag)
	);

	// Sample generator
	mskModulator u_mskModulator (
		.inClock     (inClock),
		.rstN        (rstN),
		.modBit      (modBit),
		.modEmpty    (modEmpty),
		.readBit     (readBit),
		.sinI        (sinI),
		.sinQ        (sinQ),
		.sampleValid (sampleValid),
		.phase       (phase)
	);

endmodule

/* verilog/msk_settings.svh */
`ifndef MSK_SETTINGS_SVH
`define MSK_SETTINGS_SVH

//////////////////////////////
// Input FIFO
//////////////////////////////

// Nibbles held before writes are dropped
`define IN_FIFO_DEPTH 8

//////////////////////////////
// Modulator
//////////////////////////////

// Output samples per transmitted bit
`define SAMPLES_PER_BIT 4

// Phase index width, 16 steps per carrier cycle
`define PHASE_BITS 4

`endif

/* verilog/testMux.sv */
`timescale 1ns/100ps

module testMux
	import mskPkg::*;
(
	input  logic   bypassEn,
	input  logic   bypassBit,
	input  obsSelT obsSel,
	input  logic   dataBit,
	input  logic   empty,
	input  logic   full,
	input  levelT  level,
	input  logic   readBit,
	input  sampleT sinI,
	input  sampleT sinQ,
	input  phaseT  phase,
	output logic   modBit,
	output logic   modEmpty,
	output logic   fifoRead,
	output sampleT obsData,
	output logic   obsFlag
);

	//////////////////////////////
	// Bypass
	//////////////////////////////

	// Pin source never runs dry
	always_comb begin
		modBit = bypassEn ? bypassBit : dataBit;
		modEmpty = bypassEn ? 1'b0 : empty;
		// FIFO frozen in bypass
		fifoRead = readBit && !bypassEn;
	end

	//////////////////////////////
	// Observation
	//////////////////////////////

	// One data group plus one flag per select
	always_comb begin
		case (obsSel)
			2'd0: begin
				obsData = sinI;
				obsFlag = readBit;
			end
			2'd1: begin
				obsData = sinQ;
				obsFlag = empty;
			end
			2'd2: begin
				// Fill count
				obsData = sampleT'(level);
				obsFlag = full;
			end
			default: begin
				// Phase and FIFO head bit
				obsData = sampleT'(phase);
				obsFlag = dataBit;
			end
		endcase
	end

endmodule
